// ==== hdl/conv_types_pkg.sv ====
package conv_types_pkg;

    // Pixel, weight, bias and result word
    typedef logic signed [15:0] pixel_t;

    // Dot product accumulator
    typedef logic signed [31:0] acc_t;

    typedef enum logic [1:0] {
        TARGET_IFM    = 2'd0,
        TARGET_WEIGHT = 2'd1,
        TARGET_BIAS   = 2'd2
    } mem_target_e;

    typedef struct packed {
        logic        write_en;
        mem_target_e target;
        logic [15:0] address;
        pixel_t      data;
    } load_req_t;

    typedef struct packed {
        pixel_t     data;
        logic [7:0] filter;
        logic [7:0] row;
        logic [7:0] col;
    } conv_result_t;

    localparam pixel_t PIXEL_MAX = 16'sh7fff;

endpackage

// ==== hdl/conv_ctrl_pkg.sv ====
package conv_ctrl_pkg;

    typedef enum logic [1:0] {
        SEQ_IDLE    = 2'd0,
        SEQ_WEIGHTS = 2'd1,
        SEQ_STREAM  = 2'd2,
        SEQ_FLUSH   = 2'd3
    } seq_state_e;

    // Strobes from the sequencer, valid in the cycle they are seen
    typedef struct packed {
        // Weight memory read and shift into the weight register
        logic wm_read;
        logic wm_shift;
        // Bias memory read, once per filter
        logic bm_read;
        // IFM read and line-buffer shift
        logic ifm_read;
        logic fifo_shift;
        // Full window present on this shift
        logic conv_fire;
    } unit_ctrl_t;

endpackage

// ==== hdl/sp_memory.sv ====
`timescale 1ns/1ps

module sp_memory #(
    parameter int MEM_SIZE = 16,
    localparam int ADDR_W = (MEM_SIZE > 1) ? $clog2(MEM_SIZE) : 1
) (
    input  logic                  clk,
    input  logic                  write_en,
    input  logic                  read_en,
    input  logic [ADDR_W-1:0]     address,
    input  conv_types_pkg::pixel_t write_data,
    output conv_types_pkg::pixel_t read_data
);

    conv_types_pkg::pixel_t mem [MEM_SIZE];

    // Read register holds its value between reads
    always_ff @(posedge clk) begin
        if (write_en) begin
            mem[address] <= write_data;
        end
        if (read_en) begin
            read_data <= mem[address];
        end
    end

endmodule

// ==== hdl/tdp_memory.sv ====
`timescale 1ns/1ps

module tdp_memory #(
    parameter int MEM_SIZE = 64,
    localparam int ADDR_W = (MEM_SIZE > 1) ? $clog2(MEM_SIZE) : 1
) (
    input  logic                   clk,

    input  logic                   a_write_en,
    input  logic                   a_read_en,
    input  logic [ADDR_W-1:0]      a_address,
    input  conv_types_pkg::pixel_t a_write_data,
    output conv_types_pkg::pixel_t a_read_data,

    input  logic                   b_write_en,
    input  logic                   b_read_en,
    input  logic [ADDR_W-1:0]      b_address,
    input  conv_types_pkg::pixel_t b_write_data,
    output conv_types_pkg::pixel_t b_read_data
);

    conv_types_pkg::pixel_t mem [MEM_SIZE];

    // Port B write wins on a same-address collision
    always_ff @(posedge clk) begin
        if (a_write_en) begin
            mem[a_address] <= a_write_data;
        end
        if (b_write_en) begin
            mem[b_address] <= b_write_data;
        end
        if (a_read_en) begin
            a_read_data <= mem[a_address];
        end
        if (b_read_en) begin
            b_read_data <= mem[b_address];
        end
    end

endmodule

// ==== hdl/conv_unit.sv ====
`timescale 1ns/1ps

module conv_unit #(
    parameter int IFM_SIZE          = 6,
    parameter int KERNEL_SIZE       = 3,
    parameter int NUMBER_OF_FILTERS = 2
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  conv_ctrl_pkg::unit_ctrl_t             ctrl,
    input  logic                                  weight_load_en,
    input  logic [$clog2(KERNEL_SIZE*KERNEL_SIZE*NUMBER_OF_FILTERS)-1:0] weight_address,
    input  conv_types_pkg::pixel_t                weight_data,
    input  conv_types_pkg::pixel_t                pixel_in,
    output conv_types_pkg::acc_t                  acc_out
);

    localparam int KK        = KERNEL_SIZE * KERNEL_SIZE;
    localparam int FIFO_SIZE = (KERNEL_SIZE - 1) * IFM_SIZE + KERNEL_SIZE;

    conv_types_pkg::pixel_t wm_read_data;
    conv_types_pkg::pixel_t weights [KK];
    conv_types_pkg::pixel_t fifo_q [FIFO_SIZE-1];
    conv_types_pkg::pixel_t line_taps [FIFO_SIZE];
    conv_types_pkg::acc_t   mac_sum;

    sp_memory #(
        .MEM_SIZE (KK * NUMBER_OF_FILTERS)
    ) weight_mem (
        .clk        (clk),
        .write_en   (weight_load_en),
        .read_en    (ctrl.wm_read),
        .address    (weight_address),
        .write_data (weight_data),
        .read_data  (wm_read_data)
    );

    // Tap 0 ends up at the far end after KK shifts
    always_ff @(posedge clk) begin
        if (ctrl.wm_shift) begin
            weights[0] <= wm_read_data;
            for (int k = 1; k < KK; k++) begin
                weights[k] <= weights[k-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.fifo_shift) begin
            fifo_q[0] <= pixel_in;
            for (int k = 1; k < FIFO_SIZE - 1; k++) begin
                fifo_q[k] <= fifo_q[k-1];
            end
        end
    end

    // Incoming pixel is the newest tap, so the window is complete on the firing shift
    always_comb begin
        line_taps[0] = pixel_in;
        for (int k = 1; k < FIFO_SIZE; k++) begin
            line_taps[k] = fifo_q[k-1];
        end
    end

    always_comb begin
        mac_sum = '0;
        for (int i = 0; i < KERNEL_SIZE; i++) begin
            for (int j = 0; j < KERNEL_SIZE; j++) begin
                mac_sum = mac_sum
                    + conv_types_pkg::acc_t'(line_taps[(KERNEL_SIZE-1-i)*IFM_SIZE
                                                      + (KERNEL_SIZE-1-j)])
                    * conv_types_pkg::acc_t'(weights[KK-1-(i*KERNEL_SIZE+j)]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc_out <= '0;
        end else if (ctrl.conv_fire) begin
            acc_out <= mac_sum;
        end
    end

endmodule

// ==== hdl/conv_datapath.sv ====
`timescale 1ns/1ps

module conv_datapath #(
    parameter int IFM_SIZE          = 6,
    parameter int KERNEL_SIZE       = 3,
    parameter int NUMBER_OF_FILTERS = 2,
    localparam int IFM_AW = $clog2(IFM_SIZE * IFM_SIZE),
    localparam int WM_AW  = $clog2(KERNEL_SIZE * KERNEL_SIZE * NUMBER_OF_FILTERS),
    localparam int BM_AW  = (NUMBER_OF_FILTERS > 1) ? $clog2(NUMBER_OF_FILTERS) : 1
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  conv_types_pkg::load_req_t load,
    input  logic                      load_allow,
    input  conv_ctrl_pkg::unit_ctrl_t ctrl,
    input  logic [WM_AW-1:0]          weight_read_address,
    input  logic [BM_AW-1:0]          bias_read_address,
    input  logic [IFM_AW-1:0]         ifm_read_address,
    output conv_types_pkg::pixel_t    result_data
);

    logic                   host_write;
    logic                   ifm_write_en;
    logic                   wm_write_en;
    logic                   bm_write_en;
    logic [WM_AW-1:0]       wm_address;
    logic [BM_AW-1:0]       bm_address;
    conv_types_pkg::pixel_t ifm_pixel;
    conv_types_pkg::pixel_t bias_data;
    conv_types_pkg::acc_t   acc_out;
    logic signed [32:0]     biased;

    assign host_write   = load.write_en && load_allow;
    assign ifm_write_en = host_write && (load.target == conv_types_pkg::TARGET_IFM);
    assign wm_write_en  = host_write && (load.target == conv_types_pkg::TARGET_WEIGHT);
    assign bm_write_en  = host_write && (load.target == conv_types_pkg::TARGET_BIAS);

    // Host owns the addresses while idle
    assign wm_address = load_allow ? load.address[WM_AW-1:0] : weight_read_address;
    assign bm_address = load_allow ? load.address[BM_AW-1:0] : bias_read_address;

    tdp_memory #(.MEM_SIZE(IFM_SIZE * IFM_SIZE)) ifm_mem (
        .clk          (clk),
        .a_write_en   (ifm_write_en),
        .a_read_en    (1'b0),
        .a_address    (load.address[IFM_AW-1:0]),
        .a_write_data (load.data),
        .a_read_data  (),
        .b_write_en   (1'b0),
        .b_read_en    (ctrl.ifm_read),
        .b_address    (ifm_read_address),
        .b_write_data ('0),
        .b_read_data  (ifm_pixel)
    );

    sp_memory #(.MEM_SIZE(NUMBER_OF_FILTERS)) bias_mem (
        .clk        (clk),
        .write_en   (bm_write_en),
        .read_en    (ctrl.bm_read),
        .address    (bm_address),
        .write_data (load.data),
        .read_data  (bias_data)
    );

    conv_unit #(
        .IFM_SIZE          (IFM_SIZE),
        .KERNEL_SIZE       (KERNEL_SIZE),
        .NUMBER_OF_FILTERS (NUMBER_OF_FILTERS)
    ) unit_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .ctrl           (ctrl),
        .weight_load_en (wm_write_en),
        .weight_address (wm_address),
        .weight_data    (load.data),
        .pixel_in       (ifm_pixel),
        .acc_out        (acc_out)
    );

    // One extra bit so the bias add cannot wrap
    assign biased = 33'(acc_out) + 33'(bias_data);

    // ReLU then saturate
    always_comb begin
        if (biased < 0) begin
            result_data = '0;
        end else if (biased > 33'(conv_types_pkg::PIXEL_MAX)) begin
            result_data = conv_types_pkg::PIXEL_MAX;
        end else begin
            result_data = biased[15:0];
        end
    end

endmodule

// ==== hdl/conv_sequencer.sv ====
`timescale 1ns/1ps

module conv_sequencer #(
    parameter int IFM_SIZE          = 6,
    parameter int KERNEL_SIZE       = 3,
    parameter int NUMBER_OF_FILTERS = 2,
    localparam int IFM_AW = $clog2(IFM_SIZE * IFM_SIZE),
    localparam int WM_AW  = $clog2(KERNEL_SIZE * KERNEL_SIZE * NUMBER_OF_FILTERS),
    localparam int BM_AW  = (NUMBER_OF_FILTERS > 1) ? $clog2(NUMBER_OF_FILTERS) : 1
) (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      start,
    output conv_ctrl_pkg::unit_ctrl_t ctrl,
    output logic                      load_allow,
    output logic [WM_AW-1:0]          weight_read_address,
    output logic [BM_AW-1:0]          bias_read_address,
    output logic [IFM_AW-1:0]         ifm_read_address,
    output logic                      result_valid,
    output logic [7:0]                result_filter,
    output logic [7:0]                result_row,
    output logic [7:0]                result_col,
    output logic                      busy,
    output logic                      done
);

    localparam int KK    = KERNEL_SIZE * KERNEL_SIZE;
    localparam int TAP_W = $clog2(KK + 1);
    localparam int RC_W  = $clog2(IFM_SIZE + 1);

    conv_ctrl_pkg::seq_state_e state;
    logic [TAP_W-1:0]  tap_cnt;
    logic [BM_AW-1:0]  filter_cnt;
    logic [WM_AW-1:0]  wm_addr;
    logic [IFM_AW-1:0] pix_cnt;
    logic [RC_W-1:0]   row_cnt;
    logic [RC_W-1:0]   col_cnt;
    logic              last_filter;
    logic              wm_shift_q;
    logic              fifo_shift_q;
    logic              conv_fire_q;
    logic              done_pend;
    logic [7:0]        fire_filter;
    logic [7:0]        fire_row;
    logic [7:0]        fire_col;

    assign last_filter = (filter_cnt == BM_AW'(NUMBER_OF_FILTERS - 1));
    assign load_allow  = !busy;

    assign weight_read_address = wm_addr;
    assign bias_read_address   = filter_cnt;
    assign ifm_read_address    = pix_cnt;

    // Shift strobes trail their reads by the one-cycle memory latency
    always_comb begin
        ctrl            = '0;
        ctrl.wm_read    = (state == conv_ctrl_pkg::SEQ_WEIGHTS) && (tap_cnt < TAP_W'(KK));
        ctrl.bm_read    = (state == conv_ctrl_pkg::SEQ_WEIGHTS) && (tap_cnt == '0);
        ctrl.ifm_read   = (state == conv_ctrl_pkg::SEQ_STREAM);
        ctrl.wm_shift   = wm_shift_q;
        ctrl.fifo_shift = fifo_shift_q;
        ctrl.conv_fire  = conv_fire_q;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state        <= conv_ctrl_pkg::SEQ_IDLE;
            tap_cnt      <= '0;
            filter_cnt   <= '0;
            wm_addr      <= '0;
            pix_cnt      <= '0;
            row_cnt      <= '0;
            col_cnt      <= '0;
            wm_shift_q   <= 1'b0;
            fifo_shift_q <= 1'b0;
            conv_fire_q  <= 1'b0;
            result_valid <= 1'b0;
            done_pend    <= 1'b0;
            done         <= 1'b0;
            busy         <= 1'b0;
        end else begin
            wm_shift_q   <= ctrl.wm_read;
            fifo_shift_q <= ctrl.ifm_read;
            conv_fire_q  <= ctrl.ifm_read && (row_cnt >= RC_W'(KERNEL_SIZE - 1))
                            && (col_cnt >= RC_W'(KERNEL_SIZE - 1));
            result_valid <= conv_fire_q;
            // done lands one cycle after the last result_valid
            done_pend    <= (state == conv_ctrl_pkg::SEQ_FLUSH) && last_filter;
            done         <= done_pend;
            if (done_pend) begin
                busy <= 1'b0;
            end
            case (state)
                conv_ctrl_pkg::SEQ_IDLE: begin
                    if (start && !busy) begin
                        state      <= conv_ctrl_pkg::SEQ_WEIGHTS;
                        busy       <= 1'b1;
                        filter_cnt <= '0;
                        wm_addr    <= '0;
                        tap_cnt    <= '0;
                    end
                end
                conv_ctrl_pkg::SEQ_WEIGHTS: begin
                    if (ctrl.wm_read) begin
                        wm_addr <= wm_addr + 1'b1;
                    end
                    if (tap_cnt == TAP_W'(KK)) begin
                        tap_cnt <= '0;
                        pix_cnt <= '0;
                        row_cnt <= '0;
                        col_cnt <= '0;
                        state   <= conv_ctrl_pkg::SEQ_STREAM;
                    end else begin
                        tap_cnt <= tap_cnt + 1'b1;
                    end
                end
                conv_ctrl_pkg::SEQ_STREAM: begin
                    pix_cnt <= pix_cnt + 1'b1;
                    if (col_cnt == RC_W'(IFM_SIZE - 1)) begin
                        col_cnt <= '0;
                        row_cnt <= row_cnt + 1'b1;
                    end else begin
                        col_cnt <= col_cnt + 1'b1;
                    end
                    if (pix_cnt == IFM_AW'(IFM_SIZE * IFM_SIZE - 1)) begin
                        state <= conv_ctrl_pkg::SEQ_FLUSH;
                    end
                end
                conv_ctrl_pkg::SEQ_FLUSH: begin
                    if (last_filter) begin
                        state <= conv_ctrl_pkg::SEQ_IDLE;
                    end else begin
                        filter_cnt <= filter_cnt + 1'b1;
                        state      <= conv_ctrl_pkg::SEQ_WEIGHTS;
                    end
                end
                default: state <= conv_ctrl_pkg::SEQ_IDLE;
            endcase
        end
    end

    // Window top-left, two stages to match the MAC and output stage
    always_ff @(posedge clk) begin
        fire_filter   <= 8'(filter_cnt);
        fire_row      <= 8'(row_cnt - RC_W'(KERNEL_SIZE - 1));
        fire_col      <= 8'(col_cnt - RC_W'(KERNEL_SIZE - 1));
        result_filter <= fire_filter;
        result_row    <= fire_row;
        result_col    <= fire_col;
    end

endmodule

// ==== hdl/conv_layer.sv ====
`timescale 1ns/1ps

module conv_layer #(
    parameter int IFM_SIZE          = 6,
    parameter int KERNEL_SIZE       = 3,
    parameter int NUMBER_OF_FILTERS = 2
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  conv_types_pkg::load_req_t    load,
    input  logic                         start,
    output logic                         result_valid,
    output conv_types_pkg::conv_result_t result,
    output logic                         busy,
    output logic                         done
);

    localparam int IFM_AW = $clog2(IFM_SIZE * IFM_SIZE);
    localparam int WM_AW  = $clog2(KERNEL_SIZE * KERNEL_SIZE * NUMBER_OF_FILTERS);
    localparam int BM_AW  = (NUMBER_OF_FILTERS > 1) ? $clog2(NUMBER_OF_FILTERS) : 1;

    conv_ctrl_pkg::unit_ctrl_t ctrl;
    logic                      load_allow;
    logic [WM_AW-1:0]          weight_read_address;
    logic [BM_AW-1:0]          bias_read_address;
    logic [IFM_AW-1:0]         ifm_read_address;
    conv_types_pkg::pixel_t    result_data;
    logic [7:0]                result_filter;
    logic [7:0]                result_row;
    logic [7:0]                result_col;

    assign result = '{data: result_data, filter: result_filter,
                      row: result_row, col: result_col};

    conv_sequencer #(
        .IFM_SIZE          (IFM_SIZE),
        .KERNEL_SIZE       (KERNEL_SIZE),
        .NUMBER_OF_FILTERS (NUMBER_OF_FILTERS)
    ) sequencer_i (
        .clk                 (clk),
        .rst_n               (rst_n),
        .start               (start),
        .ctrl                (ctrl),
        .load_allow          (load_allow),
        .weight_read_address (weight_read_address),
        .bias_read_address   (bias_read_address),
        .ifm_read_address    (ifm_read_address),
        .result_valid        (result_valid),
        .result_filter       (result_filter),
        .result_row          (result_row),
        .result_col          (result_col),
        .busy                (busy),
        .done                (done)
    );

    conv_datapath #(
        .IFM_SIZE          (IFM_SIZE),
        .KERNEL_SIZE       (KERNEL_SIZE),
        .NUMBER_OF_FILTERS (NUMBER_OF_FILTERS)
    ) datapath_i (
        .clk                 (clk),
        .rst_n               (rst_n),
        .load                (load),
        .load_allow          (load_allow),
        .ctrl                (ctrl),
        .weight_read_address (weight_read_address),
        .bias_read_address   (bias_read_address),
        .ifm_read_address    (ifm_read_address),
        .result_data         (result_data)
    );

endmodule

// ==== bench/conv_layer_tb.sv ====
`timescale 1ns/1ps

module conv_layer_tb;

    localparam int N  = 6;
    localparam int K  = 3;
    localparam int F  = 2;
    localparam int KK = K * K;
    localparam int RESULTS_PER_RUN = F * (N - K + 1) * (N - K + 1);

    logic                         clk = 1'b0;
    logic                         rst_n;
    conv_types_pkg::load_req_t    load;
    logic                         start;
    logic                         result_valid;
    conv_types_pkg::conv_result_t result;
    logic                         busy;
    logic                         done;

    // Reference copies of the three memories
    int ifm_m [N*N];
    int w_m [F*KK];
    int b_m [F];

    conv_types_pkg::conv_result_t expected_q [$];
    conv_types_pkg::conv_result_t exp_res;
    int                           result_count;

    conv_layer #(
        .IFM_SIZE          (N),
        .KERNEL_SIZE       (K),
        .NUMBER_OF_FILTERS (F)
    ) conv_layer_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .load         (load),
        .start        (start),
        .result_valid (result_valid),
        .result       (result),
        .busy         (busy),
        .done         (done)
    );

    always #2 clk = ~clk;

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input int got, input int expected);
        assert (got == expected) else begin
            $display("ERR t=%0t %s got %0d expected %0d", $time, name, got, expected);
            abort_run();
        end
    endtask

    assert property (@(posedge clk) !rst_n |=> !busy && !done && !result_valid) else begin
        $display("Outputs were not low while reset was held");
        abort_run();
    end

    assert property (@(posedge clk) disable iff (!rst_n) result_valid |-> busy) else begin
        $display("A result was strobed while the layer was not busy");
        abort_run();
    end

    assert property (@(posedge clk) disable iff (!rst_n)
                     done |-> !busy && $past(result_valid)) else begin
        $display("done was not raised right after the last result with busy low");
        abort_run();
    end

    assert property (@(posedge clk) disable iff (!rst_n) done |=> !done) else begin
        $display("done stayed high for more than one cycle");
        abort_run();
    end

    // Outputs are registered, so the falling edge sees them settled
    always @(negedge clk) begin
        if (rst_n && result_valid) begin
            if (expected_q.size() == 0) begin
                $display("A result arrived when no more results were expected");
                abort_run();
            end
            exp_res = expected_q.pop_front();
            check_value("result.data", int'(result.data), int'(exp_res.data));
            check_value("result.filter", int'(result.filter), int'(exp_res.filter));
            check_value("result.row", int'(result.row), int'(exp_res.row));
            check_value("result.col", int'(result.col), int'(exp_res.col));
            result_count++;
        end
    end

    task automatic load_word(input conv_types_pkg::mem_target_e target,
                             input int addr, input int data);
        @(posedge clk);
        #0.5;
        load = '{write_en: 1'b1, target: target, address: 16'(addr),
                 data: conv_types_pkg::pixel_t'(data)};
    endtask

    task automatic finish_loads();
        @(posedge clk);
        #0.5;
        load = '0;
    endtask

    task automatic load_ifm();
        for (int p = 0; p < N * N; p++) begin
            load_word(conv_types_pkg::TARGET_IFM, p, ifm_m[p]);
        end
        finish_loads();
    endtask

    task automatic load_weights_and_biases();
        for (int a = 0; a < F * KK; a++) begin
            load_word(conv_types_pkg::TARGET_WEIGHT, a, w_m[a]);
        end
        for (int f = 0; f < F; f++) begin
            load_word(conv_types_pkg::TARGET_BIAS, f, b_m[f]);
        end
        finish_loads();
    endtask

    // Filter-major, then row-major over window top-left positions
    function automatic void build_expected();
        longint sum;
        expected_q.delete();
        for (int f = 0; f < F; f++) begin
            for (int r = 0; r <= N - K; r++) begin
                for (int c = 0; c <= N - K; c++) begin
                    sum = b_m[f];
                    for (int i = 0; i < K; i++) begin
                        for (int j = 0; j < K; j++) begin
                            sum += longint'(ifm_m[(r + i) * N + c + j]) * w_m[f * KK + i * K + j];
                        end
                    end
                    if (sum < 0) begin
                        sum = 0;
                    end else if (sum > conv_types_pkg::PIXEL_MAX) begin
                        sum = conv_types_pkg::PIXEL_MAX;
                    end
                    expected_q.push_back('{data: conv_types_pkg::pixel_t'(sum),
                                           filter: 8'(f), row: 8'(r), col: 8'(c)});
                end
            end
        end
    endfunction

    // With noisy set, random host writes are issued for the whole run
    task automatic run_layer(input bit noisy);
        int cycles;
        cycles = 0;
        result_count = 0;
        @(posedge clk);
        #0.5;
        start = 1'b1;
        @(posedge clk);
        #0.5;
        start = 1'b0;
        while (done !== 1'b1) begin
            check_value("busy", int'(busy), 1);
            if (noisy) begin
                load = '{write_en: 1'b1,
                         target: conv_types_pkg::mem_target_e'($urandom_range(2)),
                         address: 16'($urandom_range(N * N - 1)),
                         data: conv_types_pkg::pixel_t'($urandom)};
            end
            @(posedge clk);
            #0.5;
            cycles++;
            if (cycles > 2000) begin
                $display("Timeout: done did not arrive within 2000 cycles of start");
                abort_run();
            end
        end
        load = '0;
        check_value("result count", result_count, RESULTS_PER_RUN);
    endtask

    initial begin
        void'($urandom(32'hce93_eab3));
        rst_n = 1'b0;
        load  = '0;
        start = 1'b0;
        repeat (8) @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        check_value("busy", int'(busy), 0);
        check_value("done", int'(done), 0);
        check_value("result_valid", int'(result_valid), 0);

        // Small random pixels, weights and biases
        for (int p = 0; p < N * N; p++) begin
            ifm_m[p] = int'($urandom_range(15)) - 8;
        end
        for (int a = 0; a < F * KK; a++) begin
            w_m[a] = int'($urandom_range(15)) - 8;
        end
        for (int f = 0; f < F; f++) begin
            b_m[f] = int'($urandom_range(100)) - 50;
        end
        load_ifm();
        load_weights_and_biases();
        build_expected();
        run_layer(1'b0);

        // Large negative bias clamps every filter 1 result to zero
        b_m[1] = -30000;
        load_weights_and_biases();
        build_expected();
        run_layer(1'b0);

        // Full-scale pixels push the sums past the pixel range
        for (int p = 0; p < N * N; p++) begin
            ifm_m[p] = conv_types_pkg::PIXEL_MAX;
        end
        for (int a = 0; a < KK; a++) begin
            w_m[a] = int'($urandom_range(3000)) + 1;
            w_m[KK + a] = int'($urandom_range(6000)) - 3000;
        end
        b_m[0] = 0;
        b_m[1] = 0;
        load_ifm();
        load_weights_and_biases();
        build_expected();
        run_layer(1'b0);

        // Writes during the run must not reach any memory
        build_expected();
        run_layer(1'b1);

        // Fresh weights and biases over the IFM left by the previous runs
        for (int a = 0; a < F * KK; a++) begin
            w_m[a] = int'($urandom_range(15)) - 8;
        end
        for (int f = 0; f < F; f++) begin
            b_m[f] = int'($urandom_range(2000)) - 1000;
        end
        load_weights_and_biases();
        build_expected();
        run_layer(1'b0);

        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== flist.f ====
hdl/conv_types_pkg.sv
hdl/conv_ctrl_pkg.sv
hdl/sp_memory.sv
hdl/tdp_memory.sv
hdl/conv_unit.sv
hdl/conv_datapath.sv
hdl/conv_sequencer.sv
hdl/conv_layer.sv
bench/conv_layer_tb.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --top-module conv_layer_tb \
		-Mdir obj_dir -f flist.f
	./obj_dir/Vconv_layer_tb

clean:
	rm -rf obj_dir
